// ==== sysctl_pkg.sv ====
`default_nettype none

package sysctl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  localparam int addr_w    = 32;
  localparam int sel_w     = 16;
  localparam int int_n     = 16;
  localparam int int_idx_w = 4;

  // flushable pipeline stages, fetch first
  localparam int pipe_flush_n = 7;

  localparam int fl_fetch     = 0;
  localparam int fl_decode_0  = 1;
  localparam int fl_decode_1  = 2;
  localparam int fl_register  = 3;
  localparam int fl_address   = 4;
  localparam int fl_execute   = 5;
  localparam int fl_writeback = 6;

  ////////////////////////////////////////////////////////////////////////////
  // handler address per interrupt line

  localparam logic [addr_w-1:0] idt_table [int_n] = '{
    32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 32'h0000_f000,
    32'h0000_f000, 32'h0000_f000, 32'h0000_f000, 32'h0000_f000,
    32'h0000_4000, 32'h0000_8000, 32'h0000_c000, 32'h0000_f000,
    32'h0000_f000, 32'h0000_f000, 32'h0000_f000, 32'h0000_f000
  };

  ////////////////////////////////////////////////////////////////////////////
  // sequencer states

  typedef enum logic [1:0] {
    int_idle,
    int_req,
    int_data,
    int_decode
  } int_state_t;

  typedef enum logic [1:0] {
    ret_idle,
    ret_pop_eflags,
    ret_pop_cs,
    ret_pop_eip
  } ret_state_t;

endpackage

`default_nettype wire

// ==== int_pending.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_pending
  import sysctl_pkg::*;
(
  input  logic                 or_int_vec,
  input  logic                 rst,
  input  logic [int_n-1:0]     int_vec,
  input  logic                 int_clear,
  input  logic [int_idx_w-1:0] clear_idx,
  output logic                 pending_int,
  output logic [int_idx_w-1:0] serv_idx
);

  logic [int_n-1:0] req_q;
  logic [int_n-1:0] req_d;
  logic [int_n-1:0] clr_mask;

  ////////////////////////////////////////////////////////////////////////////
  // sticky request vector

  // one-hot mask of the line being retired
  always_comb begin
    clr_mask = '0;
    if (int_clear) begin
      clr_mask[clear_idx] = 1'b1;
    end
  end

  // new requests merge in, the retired line drops out
  // even if it is raised again in the same cycle
  always_comb begin
    req_d = (req_q | int_vec) & ~clr_mask;
  end

  always_ff @(posedge or_int_vec) begin
    if (rst) begin
      req_q <= '0;
    end else begin
      req_q <= req_d;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // summary and priority pick

  assign pending_int = |req_q;

  // lowest index wins, scan from the top so the last hit is the lowest
  always_comb begin
    serv_idx = '0;
    for (int i = int_n - 1; i >= 0; i--) begin
      if (req_q[i]) begin
        serv_idx = int_idx_w'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== int_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_sequencer
  import sysctl_pkg::*;
(
  input  logic                    or_int_vec,
  input  logic                    rst,
  input  logic                    pending_int,
  input  logic [int_idx_w-1:0]    serv_idx,
  input  logic                    hold_int,
  input  logic                    ret_busy,
  output logic                    mem_valid,
  input  logic                    mem_ready,
  output logic [addr_w-1:0]       mem_address,
  input  logic                    mem_dp_valid,
  output logic                    mem_dp_ready,
  input  logic [addr_w-1:0]       mem_dp_read_data,
  output logic                    int_fetch_load,
  output logic [addr_w-1:0]       int_fetch_address,
  output logic [pipe_flush_n-1:0] int_flush,
  output logic                    decode_start_int,
  input  logic                    decode_end_int,
  output logic                    int_clear,
  output logic [int_idx_w-1:0]    clear_idx
);

  int_state_t           state;
  int_state_t           state_nxt;
  logic [int_idx_w-1:0] cur_idx;
  logic                 start;

  // a return in flight owns fetch, so entry waits for it
  assign start = pending_int & ~hold_int & ~ret_busy;

  ////////////////////////////////////////////////////////////////////////////
  // state register

  always_ff @(posedge or_int_vec) begin
    if (rst) begin
      state <= int_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // index is frozen for the whole entry sequence
  always_ff @(posedge or_int_vec) begin
    if (state == int_idle && start) begin
      cur_idx <= serv_idx;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      int_idle:   if (start) state_nxt = int_req;
      int_req:    if (mem_ready) state_nxt = int_data;
      int_data:   if (mem_dp_valid) state_nxt = int_decode;
      int_decode: if (decode_end_int) state_nxt = int_idle;
      default:    state_nxt = int_idle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // vector table read

  assign mem_valid    = (state == int_req);
  assign mem_address  = (state == int_req) ? idt_table[cur_idx] : '0;
  assign mem_dp_ready = (state == int_data);

  ////////////////////////////////////////////////////////////////////////////
  // redirect, flush and retire on the data beat

  assign int_fetch_load    = (state == int_data) & mem_dp_valid;
  assign int_fetch_address = mem_dp_read_data;
  assign int_flush         = {pipe_flush_n{int_fetch_load}};
  assign int_clear         = int_fetch_load;
  assign clear_idx         = cur_idx;

  // decode runs the entry microcode until it reports done
  assign decode_start_int = (state == int_decode);

endmodule

`default_nettype wire

// ==== ret_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module ret_sequencer
  import sysctl_pkg::*;
(
  input  logic              or_int_vec,
  input  logic              rst,
  input  logic              iretd,
  input  logic              ret_far,
  input  logic              ret_near,
  input  logic [sel_w-1:0]  cs_register,
  input  logic              iretd_pop_valid,
  input  logic [addr_w-1:0] iretd_pop_data,
  output logic              ret_busy,
  output logic              ret_load_eflags,
  output logic              ret_load_cs,
  output logic              ret_load_eip,
  output logic              ret_fetch_load,
  output logic [addr_w-1:0] ret_fetch_address
);

  ret_state_t       state;
  ret_state_t       state_nxt;
  logic             near_q;
  logic [sel_w-1:0] temp_cs;
  logic [sel_w-1:0] used_cs;

  ////////////////////////////////////////////////////////////////////////////
  // state register

  always_ff @(posedge or_int_vec) begin
    if (rst) begin
      state  <= ret_idle;
      near_q <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == ret_idle) begin
        near_q <= ~iretd & ~ret_far & ret_near;
      end
    end
  end

  // iretd skips nothing, far skips eflags, near goes straight to eip
  always_comb begin
    state_nxt = state;
    case (state)
      ret_idle: begin
        if (iretd) begin
          state_nxt = ret_pop_eflags;
        end else if (ret_far) begin
          state_nxt = ret_pop_cs;
        end else if (ret_near) begin
          state_nxt = ret_pop_eip;
        end
      end
      ret_pop_eflags: if (iretd_pop_valid) state_nxt = ret_pop_cs;
      ret_pop_cs:     if (iretd_pop_valid) state_nxt = ret_pop_eip;
      ret_pop_eip:    if (iretd_pop_valid) state_nxt = ret_idle;
      default:        state_nxt = ret_idle;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // pop strobes

  assign ret_busy        = (state != ret_idle);
  assign ret_load_eflags = (state == ret_pop_eflags) & iretd_pop_valid;
  assign ret_load_cs     = (state == ret_pop_cs) & iretd_pop_valid;
  assign ret_load_eip    = (state == ret_pop_eip) & iretd_pop_valid;
  assign ret_fetch_load  = ret_load_eip;

  // popped selector kept for the eip step
  always_ff @(posedge or_int_vec) begin
    if (ret_load_cs) begin
      temp_cs <= iretd_pop_data[sel_w-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // return target

  assign used_cs = near_q ? cs_register : temp_cs;

  assign ret_fetch_address = iretd_pop_data + {{(addr_w - sel_w){1'b0}}, used_cs};

endmodule

`default_nettype wire

// ==== flow_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module flow_merge
  import sysctl_pkg::*;
(
  input  logic                    or_int_vec,
  input  logic                    rst,
  input  logic                    int_fetch_load,
  input  logic [addr_w-1:0]       int_fetch_address,
  input  logic [pipe_flush_n-1:0] int_flush,
  input  logic                    ret_busy,
  input  logic                    ret_load_eflags,
  input  logic                    ret_load_cs,
  input  logic                    ret_load_eip,
  input  logic                    ret_fetch_load,
  input  logic [addr_w-1:0]       ret_fetch_address,
  input  logic [addr_w-1:0]       iretd_pop_data,
  input  logic                    jump_load,
  input  logic [addr_w-1:0]       jump_load_address,
  input  logic                    jump_load_cs,
  input  logic [sel_w-1:0]        jump_cs,
  output logic                    flush_fetch,
  output logic                    flush_decode_0,
  output logic                    flush_decode_1,
  output logic                    flush_register,
  output logic                    flush_address,
  output logic                    flush_execute,
  output logic                    flush_writeback,
  output logic                    fetch_load,
  output logic [addr_w-1:0]       fetch_load_address,
  output logic                    reg_load_eflags,
  output logic [addr_w-1:0]       reg_eflags,
  output logic                    reg_load_cs,
  output logic [sel_w-1:0]        reg_cs,
  output logic                    reg_load_eip,
  output logic [addr_w-1:0]       reg_eip
);

  logic              jmp_q;
  logic [addr_w-1:0] jmp_addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // jump stage

  always_ff @(posedge or_int_vec) begin
    if (rst) begin
      jmp_q <= 1'b0;
    end else begin
      jmp_q <= jump_load;
    end
  end

  always_ff @(posedge or_int_vec) begin
    jmp_addr_q <= jump_load_address;
  end

  ////////////////////////////////////////////////////////////////////////////
  // flushes, a jump leaves writeback alone

  assign flush_fetch     = int_flush[fl_fetch] | ret_busy | jmp_q;
  assign flush_decode_0  = int_flush[fl_decode_0] | jmp_q;
  assign flush_decode_1  = int_flush[fl_decode_1] | jmp_q;
  assign flush_register  = int_flush[fl_register] | jmp_q;
  assign flush_address   = int_flush[fl_address] | jmp_q;
  assign flush_execute   = int_flush[fl_execute] | jmp_q;
  assign flush_writeback = int_flush[fl_writeback];

  ////////////////////////////////////////////////////////////////////////////
  // fetch redirect, interrupt over return over jump

  assign fetch_load = int_fetch_load | ret_fetch_load | jmp_q;

  always_comb begin
    if (int_fetch_load) begin
      fetch_load_address = int_fetch_address;
    end else if (ret_fetch_load) begin
      fetch_load_address = ret_fetch_address;
    end else begin
      fetch_load_address = jmp_addr_q;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // register loads

  // eflags and eip only ever come off the stack
  assign reg_load_eflags = ret_load_eflags;
  assign reg_eflags      = iretd_pop_data;
  assign reg_load_eip    = ret_load_eip;
  assign reg_eip         = iretd_pop_data;

  // jump cs is not registered, it goes out with its own cycle
  assign reg_load_cs = ret_load_cs | jump_load_cs;
  assign reg_cs      = ret_load_cs ? iretd_pop_data[sel_w-1:0] : jump_cs;

endmodule

`default_nettype wire

// ==== sys_cont_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sys_cont_top
  import sysctl_pkg::*;
(
  input  logic              or_int_vec,
  input  logic              rst,
  input  logic [int_n-1:0]  int_vec,
  input  logic [sel_w-1:0]  cs_register,
  output logic              mem_valid,
  input  logic              mem_ready,
  output logic [addr_w-1:0] mem_address,
  input  logic              mem_dp_valid,
  output logic              mem_dp_ready,
  input  logic [addr_w-1:0] mem_dp_read_data,
  output logic              flush_fetch,
  output logic              flush_decode_0,
  output logic              flush_decode_1,
  output logic              flush_register,
  output logic              flush_address,
  output logic              flush_execute,
  output logic              flush_writeback,
  output logic              fetch_load,
  output logic [addr_w-1:0] fetch_load_address,
  output logic              decode_start_int,
  input  logic              decode_end_int,
  output logic              reg_load_cs,
  output logic [sel_w-1:0]  reg_cs,
  input  logic              ret_near,
  input  logic              ret_far,
  input  logic              iretd,
  output logic              iretd_halt,
  input  logic              iretd_pop_valid,
  input  logic [addr_w-1:0] iretd_pop_data,
  output logic              reg_load_eflags,
  output logic [addr_w-1:0] reg_eflags,
  output logic              reg_load_eip,
  output logic [addr_w-1:0] reg_eip,
  output logic              pending_int,
  input  logic              hold_int,
  input  logic              jump_load,
  input  logic [addr_w-1:0] jump_load_address,
  input  logic              jump_load_cs,
  input  logic [sel_w-1:0]  jump_cs
);

  logic [int_idx_w-1:0]    serv_idx;
  logic                    int_clear;
  logic [int_idx_w-1:0]    clear_idx;
  logic                    int_fetch_load;
  logic [addr_w-1:0]       int_fetch_address;
  logic [pipe_flush_n-1:0] int_flush;
  logic                    ret_busy;
  logic                    ret_load_eflags;
  logic                    ret_load_cs;
  logic                    ret_load_eip;
  logic                    ret_fetch_load;
  logic [addr_w-1:0]       ret_fetch_address;

  assign iretd_halt = ret_busy;

  ////////////////////////////////////////////////////////////////////////////
  // interrupt side

  int_pending u_int_pending (
    .or_int_vec  (or_int_vec),
    .rst         (rst),
    .int_vec     (int_vec),
    .int_clear   (int_clear),
    .clear_idx   (clear_idx),
    .pending_int (pending_int),
    .serv_idx    (serv_idx)
  );

  int_sequencer u_int_sequencer (
    .or_int_vec        (or_int_vec),
    .rst               (rst),
    .pending_int       (pending_int),
    .serv_idx          (serv_idx),
    .hold_int          (hold_int),
    .ret_busy          (ret_busy),
    .mem_valid         (mem_valid),
    .mem_ready         (mem_ready),
    .mem_address       (mem_address),
    .mem_dp_valid      (mem_dp_valid),
    .mem_dp_ready      (mem_dp_ready),
    .mem_dp_read_data  (mem_dp_read_data),
    .int_fetch_load    (int_fetch_load),
    .int_fetch_address (int_fetch_address),
    .int_flush         (int_flush),
    .decode_start_int  (decode_start_int),
    .decode_end_int    (decode_end_int),
    .int_clear         (int_clear),
    .clear_idx         (clear_idx)
  );

  ////////////////////////////////////////////////////////////////////////////
  // return side

  ret_sequencer u_ret_sequencer (
    .or_int_vec        (or_int_vec),
    .rst               (rst),
    .iretd             (iretd),
    .ret_far           (ret_far),
    .ret_near          (ret_near),
    .cs_register       (cs_register),
    .iretd_pop_valid   (iretd_pop_valid),
    .iretd_pop_data    (iretd_pop_data),
    .ret_busy          (ret_busy),
    .ret_load_eflags   (ret_load_eflags),
    .ret_load_cs       (ret_load_cs),
    .ret_load_eip      (ret_load_eip),
    .ret_fetch_load    (ret_fetch_load),
    .ret_fetch_address (ret_fetch_address)
  );

  ////////////////////////////////////////////////////////////////////////////
  // jump path and output merge

  flow_merge u_flow_merge (
    .or_int_vec         (or_int_vec),
    .rst                (rst),
    .int_fetch_load     (int_fetch_load),
    .int_fetch_address  (int_fetch_address),
    .int_flush          (int_flush),
    .ret_busy           (ret_busy),
    .ret_load_eflags    (ret_load_eflags),
    .ret_load_cs        (ret_load_cs),
    .ret_load_eip       (ret_load_eip),
    .ret_fetch_load     (ret_fetch_load),
    .ret_fetch_address  (ret_fetch_address),
    .iretd_pop_data     (iretd_pop_data),
    .jump_load          (jump_load),
    .jump_load_address  (jump_load_address),
    .jump_load_cs       (jump_load_cs),
    .jump_cs            (jump_cs),
    .flush_fetch        (flush_fetch),
    .flush_decode_0     (flush_decode_0),
    .flush_decode_1     (flush_decode_1),
    .flush_register     (flush_register),
    .flush_address      (flush_address),
    .flush_execute      (flush_execute),
    .flush_writeback    (flush_writeback),
    .fetch_load         (fetch_load),
    .fetch_load_address (fetch_load_address),
    .reg_load_eflags    (reg_load_eflags),
    .reg_eflags         (reg_eflags),
    .reg_load_cs        (reg_load_cs),
    .reg_cs             (reg_cs),
    .reg_load_eip       (reg_load_eip),
    .reg_eip            (reg_eip)
  );

endmodule

`default_nettype wire

// ==== tb_sys_cont_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sys_cont_top
  import sysctl_pkg::*;
();

  localparam int test_cycles = 500;
  // about four times what the tests need
  localparam int max_cycles  = 4 * test_cycles;

  logic              or_int_vec;
  logic              rst;
  logic [int_n-1:0]  int_vec;
  logic [sel_w-1:0]  cs_register;
  logic              mem_ready;
  logic              mem_dp_valid;
  logic              decode_end_int;
  logic              hold_int;
  logic              iretd;
  logic              ret_far;
  logic              ret_near;
  logic              iretd_pop_valid;
  logic              jump_load;
  logic              jump_load_cs;
  logic [addr_w-1:0] mem_dp_read_data;
  logic [addr_w-1:0] iretd_pop_data;
  logic [addr_w-1:0] jump_load_address;
  logic [sel_w-1:0]  jump_cs;
  logic              mem_valid;
  logic              mem_dp_ready;
  logic              decode_start_int;
  logic              iretd_halt;
  logic              pending_int;
  logic              flush_fetch;
  logic              flush_decode_0;
  logic              flush_decode_1;
  logic              flush_register;
  logic              flush_address;
  logic              flush_execute;
  logic              flush_writeback;
  logic              fetch_load;
  logic              reg_load_cs;
  logic              reg_load_eflags;
  logic              reg_load_eip;
  logic [addr_w-1:0] mem_address;
  logic [addr_w-1:0] fetch_load_address;
  logic [addr_w-1:0] reg_eflags;
  logic [addr_w-1:0] reg_eip;
  logic [sel_w-1:0]  reg_cs;

  // expected redirects, register loads and serviced lines with the oldest first
  logic [addr_w-1:0]       fetch_q[$];
  logic [pipe_flush_n-1:0] flush_q[$];
  int                      load_kind_q[$];
  logic [addr_w-1:0]       load_val_q[$];
  int                      idx_q[$];

  logic [31:0] seed;
  int          errors  = 0;
  int          checks  = 0;
  int          cycles  = 0;
  int          entries = 0;
  int          ends    = 0;

  sys_cont_top u_sys_cont_top (.*);

  always #5 or_int_vec = ~or_int_vec;

  function automatic logic [31:0] next_random();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic wait_for_ends(input int n);
    while (ends < n) begin
      @(posedge or_int_vec);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // monitors sample on the edge and see last cycle's settled values

  always @(posedge or_int_vec) begin : fetch_monitor
    logic [pipe_flush_n-1:0] flushes;
    flushes = {flush_writeback, flush_execute, flush_address, flush_register,
               flush_decode_1, flush_decode_0, flush_fetch};
    if (!rst && fetch_load === 1'b1) begin
      if (fetch_q.size() == 0) begin
        errors++;
        $display("fetch_load at %0t with no redirect expected", $time);
      end else begin
        check_value("fetch address", fetch_q.pop_front(), fetch_load_address);
        check_value("flush pattern", flush_q.pop_front(), flushes);
      end
    end
  end

  // 0 eflags, 1 cs, 2 eip
  always @(posedge or_int_vec) begin : load_monitor
    int                kind;
    logic [addr_w-1:0] value;
    kind  = -1;
    value = '0;
    if (rst) begin
      kind = -1;
    end else if (reg_load_eflags === 1'b1) begin
      kind  = 0;
      value = reg_eflags;
    end else if (reg_load_cs === 1'b1) begin
      kind  = 1;
      value = reg_cs;
    end else if (reg_load_eip === 1'b1) begin
      kind  = 2;
      value = reg_eip;
    end
    if (kind >= 0) begin
      if (load_kind_q.size() == 0) begin
        errors++;
        $display("register load at %0t with none expected", $time);
      end else begin
        check_value("register load order", load_kind_q.pop_front(), kind);
        check_value("register load data", load_val_q.pop_front(), value);
      end
    end
  end

  always @(posedge or_int_vec) begin : rule_monitor
    if (!rst) begin
      assert (iretd_halt !== 1'b1 || flush_fetch === 1'b1) else begin
        errors++;
        $display("iretd_halt high at %0t without flush_fetch", $time);
      end
      assert (flush_writeback !== 1'b1 || fetch_load === 1'b1) else begin
        errors++;
        $display("writeback flushed at %0t without a redirect", $time);
      end
    end
  end

  always @(posedge or_int_vec) begin : watchdog
    cycles++;
    if (cycles >= max_cycles) begin
      $display("timeout after %0d cycles, a handshake never completed", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // vector table memory and decode responders

  always begin : mem_responder
    int                gap;
    logic [addr_w-1:0] exp_addr;
    logic [addr_w-1:0] word;
    @(posedge or_int_vec);
    if (!rst && mem_valid === 1'b1) begin
      check_value("entry starts after decode_end_int", ends, entries);
      entries++;
      exp_addr = '0;
      if (idx_q.size() == 0) begin
        errors++;
        $display("mem_valid at %0t with no pending line expected", $time);
      end else begin
        exp_addr = idt_table[idx_q.pop_front()];
      end
      check_value("idt address", exp_addr, mem_address);
      gap = 1 + next_random() % 3;
      repeat (gap) begin
        @(posedge or_int_vec);
        check_value("mem_valid held", 1, mem_valid);
        check_value("idt address held", exp_addr, mem_address);
      end
      mem_ready <= 1'b1;
      @(posedge or_int_vec);
      mem_ready <= 1'b0;
      while (mem_dp_ready !== 1'b1) begin
        @(posedge or_int_vec);
      end
      gap = 1 + next_random() % 3;
      repeat (gap) begin
        mem_dp_read_data <= next_random();
        @(posedge or_int_vec);
      end
      word = next_random();
      mem_dp_valid     <= 1'b1;
      mem_dp_read_data <= word;
      fetch_q.push_back(word);
      flush_q.push_back(7'h7f);
      @(posedge or_int_vec);
      mem_dp_valid <= 1'b0;
    end
  end

  always begin : decode_responder
    int gap;
    @(posedge or_int_vec);
    if (!rst && decode_start_int === 1'b1) begin
      gap = next_random() % 4;
      repeat (gap) begin
        @(posedge or_int_vec);
      end
      decode_end_int <= 1'b1;
      @(posedge or_int_vec);
      decode_end_int <= 1'b0;
      ends++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus

  task automatic run_jump();
    logic [addr_w-1:0] target;
    logic [sel_w-1:0]  sel;
    target = next_random();
    sel    = sel_w'(next_random());
    @(posedge or_int_vec);
    jump_load         <= 1'b1;
    jump_load_address <= target;
    jump_load_cs      <= 1'b1;
    jump_cs           <= sel;
    fetch_q.push_back(target);
    flush_q.push_back(7'h3f);
    load_kind_q.push_back(1);
    load_val_q.push_back(sel);
    @(posedge or_int_vec);
    jump_load         <= 1'b0;
    jump_load_cs      <= 1'b0;
    jump_load_address <= next_random();
    check_value("jump fetch_load early", 0, fetch_load);
    check_value("jump reg_load_cs same cycle", 1, reg_load_cs);
    check_value("jump reg_cs same cycle", sel, reg_cs);
    @(posedge or_int_vec);
    check_value("jump fetch_load", 1, fetch_load);
    check_value("jump flush_writeback", 0, flush_writeback);
  endtask

  // kind 0 iretd, 1 far return, 2 near return
  task automatic run_return(input int kind);
    logic [addr_w-1:0] words[3];
    logic [sel_w-1:0]  sel;
    int                n;
    int                k;
    int                gap;
    for (int i = 0; i < 3; i++) begin
      words[i] = next_random();
    end
    n   = 3 - kind;
    sel = (n == 1) ? sel_w'(next_random()) : words[n-2][sel_w-1:0];
    for (int i = 0; i < n; i++) begin
      k = 3 - n + i;
      load_kind_q.push_back(k);
      load_val_q.push_back((k == 1) ? {16'h0, words[i][sel_w-1:0]} : words[i]);
    end
    fetch_q.push_back(words[n-1] + {16'h0, sel});
    flush_q.push_back(7'h01);
    @(posedge or_int_vec);
    if (n == 1) begin
      cs_register <= sel;
    end
    iretd    <= (kind == 0);
    ret_far  <= (kind == 1);
    ret_near <= (kind == 2);
    @(posedge or_int_vec);
    iretd    <= 1'b0;
    ret_far  <= 1'b0;
    ret_near <= 1'b0;
    for (int i = 0; i < n; i++) begin
      gap = next_random() % 4;
      repeat (gap) begin
        iretd_pop_valid <= 1'b0;
        iretd_pop_data  <= next_random();
        @(posedge or_int_vec);
        check_value("iretd_halt while popping", 1, iretd_halt);
      end
      iretd_pop_valid <= 1'b1;
      iretd_pop_data  <= words[i];
      @(posedge or_int_vec);
      check_value("iretd_halt on pop", 1, iretd_halt);
    end
    iretd_pop_valid <= 1'b0;
    @(posedge or_int_vec);
    check_value("iretd_halt after last pop", 0, iretd_halt);
  endtask

  initial begin
    seed              = 32'hcb09_eccc;
    or_int_vec        = 1'b0;
    rst               = 1'b1;
    int_vec           = '0;
    cs_register       = '0;
    mem_ready         = 1'b0;
    mem_dp_valid      = 1'b0;
    mem_dp_read_data  = '0;
    decode_end_int    = 1'b0;
    hold_int          = 1'b0;
    iretd             = 1'b0;
    ret_far           = 1'b0;
    ret_near          = 1'b0;
    iretd_pop_valid   = 1'b0;
    iretd_pop_data    = '0;
    jump_load         = 1'b0;
    jump_load_address = '0;
    jump_load_cs      = 1'b0;
    jump_cs           = '0;
    repeat (3) @(posedge or_int_vec);
    rst <= 1'b0;
    @(posedge or_int_vec);
    check_value("controls after reset", 0,
                {mem_valid, mem_dp_ready, decode_start_int, iretd_halt, pending_int,
                 flush_fetch, flush_decode_0, flush_decode_1, flush_register,
                 flush_address, flush_execute, flush_writeback, fetch_load,
                 reg_load_eflags, reg_load_cs, reg_load_eip});

    run_jump();
    run_jump();

    // two lines at once and the lowest index goes first
    idx_q.push_back(2);
    idx_q.push_back(8);
    @(posedge or_int_vec);
    int_vec <= 16'h0104;
    @(posedge or_int_vec);
    int_vec <= '0;
    @(posedge or_int_vec);
    check_value("pending_int after request", 1, pending_int);
    wait_for_ends(2);
    @(posedge or_int_vec);
    check_value("pending_int after both cleared", 0, pending_int);

    idx_q.push_back(5);
    @(posedge or_int_vec);
    hold_int <= 1'b1;
    int_vec  <= 16'h0020;
    @(posedge or_int_vec);
    int_vec <= '0;
    repeat (6) begin
      @(posedge or_int_vec);
      check_value("mem_valid under hold_int", 0, mem_valid);
    end
    check_value("request kept under hold_int", 1, pending_int);
    hold_int <= 1'b0;
    wait_for_ends(3);

    run_return(0);
    run_return(1);
    run_return(2);

    repeat (4) @(posedge or_int_vec);
    if (fetch_q.size() != 0 || load_kind_q.size() != 0 || idx_q.size() != 0) begin
      errors++;
      $display("%0d redirects, %0d register loads and %0d entries never arrived",
               fetch_q.size(), load_kind_q.size(), idx_q.size());
    end
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sys_cont_top.f ====
sysctl_pkg.sv
int_pending.sv
int_sequencer.sv
ret_sequencer.sv
flow_merge.sv
sys_cont_top.sv
tb_sys_cont_top.sv
